//--- verilog/mips_pkg.sv
package mips_pkg;

	// datapath widths
	localparam int XLEN   = 32;
	localparam int REG_AW = 5;
	localparam int BE_W   = 4;

	localparam int ALU_OP_W = 4;
	localparam int MEM_OP_W = 4;

	// ALU operation
	typedef enum logic [ALU_OP_W-1:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_NOR  = 4'd5,
		ALU_SLT  = 4'd6,
		ALU_SLTU = 4'd7,
		ALU_SLL  = 4'd8,
		ALU_SRL  = 4'd9,
		ALU_SRA  = 4'd10,
		ALU_LUI  = 4'd11
	} alu_op_e;

	// memory operation, zero means no access
	typedef enum logic [MEM_OP_W-1:0] {
		MEM_NONE = 4'd0,
		MEM_LB   = 4'd1,
		MEM_LBU  = 4'd2,
		MEM_LH   = 4'd3,
		MEM_LHU  = 4'd4,
		MEM_LW   = 4'd5,
		MEM_SB   = 4'd6,
		MEM_SH   = 4'd7,
		MEM_SW   = 4'd8
	} mem_op_e;

	function automatic logic is_load(input mem_op_e op);
		logic res;
		case (op)
			MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW: res = 1'b1;
			default: res = 1'b0;
		endcase
		return res;
	endfunction

	function automatic logic is_store(input mem_op_e op);
		logic res;
		case (op)
			MEM_SB, MEM_SH, MEM_SW: res = 1'b1;
			default: res = 1'b0;
		endcase
		return res;
	endfunction

endpackage

//--- verilog/alu.sv
`timescale 1ns/10ps

module alu
	import mips_pkg::*;
(
	input  logic [XLEN-1:0] opr1_i,
	input  logic [XLEN-1:0] opr2_i,
	input  alu_op_e         aluop_i,
	output logic [XLEN-1:0] res_o
);

	logic [4:0]      shamt;
	logic            opr_lt;
	logic            opr_ltu;
	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] diff;

	assign shamt   = opr1_i[4:0];	// shift amount from rs side
	assign sum     = opr1_i + opr2_i;
	assign diff    = opr1_i - opr2_i;
	assign opr_lt  = $signed(opr1_i) < $signed(opr2_i);
	assign opr_ltu = opr1_i < opr2_i;

	always_comb begin
		case (aluop_i)
			ALU_ADD: begin
				res_o = sum;
			end
			ALU_SUB: begin
				res_o = diff;
			end
			ALU_AND: begin
				res_o = opr1_i & opr2_i;
			end
			ALU_OR: begin
				res_o = opr1_i | opr2_i;
			end
			ALU_XOR: begin
				res_o = opr1_i ^ opr2_i;
			end
			ALU_NOR: begin
				res_o = ~(opr1_i | opr2_i);
			end
			ALU_SLT: begin
				res_o = {{(XLEN-1){1'b0}}, opr_lt};
			end
			ALU_SLTU: begin
				res_o = {{(XLEN-1){1'b0}}, opr_ltu};
			end
			ALU_SLL: begin
				res_o = opr2_i << shamt;
			end
			ALU_SRL: begin
				res_o = opr2_i >> shamt;
			end
			ALU_SRA: begin
				res_o = $unsigned($signed(opr2_i) >>> shamt);	// keeps sign bit
			end
			ALU_LUI: begin
				res_o = {opr2_i[XLEN/2-1:0], {(XLEN/2){1'b0}}};
			end
			default: begin
				res_o = '0;
			end
		endcase
	end

endmodule

//--- verilog/store_format.sv
`timescale 1ns/10ps

module store_format
	import mips_pkg::*;
(
	input  logic [XLEN-1:0] addr_i,
	input  logic [XLEN-1:0] rtvalue_i,
	input  mem_op_e         memop_i,
	output logic            sram_en_o,
	output logic [BE_W-1:0] sram_wen_o,
	output logic [XLEN-1:0] sram_addr_o,
	output logic [XLEN-1:0] sram_wdata_o
);

	logic [1:0]      addr_low;
	logic [BE_W-1:0] wen_sb;
	logic [BE_W-1:0] wen_sh;

	assign addr_low = addr_i[1:0];
	assign wen_sb   = 4'b0001 << addr_low;	// one lane per byte offset
	assign wen_sh   = addr_low[1] ? 4'b1100 : 4'b0011;

	assign sram_en_o   = (memop_i != MEM_NONE);
	assign sram_addr_o = {addr_i[XLEN-1:2], 2'b00};	// word aligned

	always_comb begin
		sram_wen_o = '0;
		if (is_store(memop_i)) begin
			case (memop_i)
				MEM_SB:  sram_wen_o = wen_sb;
				MEM_SH:  sram_wen_o = wen_sh;
				default: sram_wen_o = '1;
			endcase
		end
	end

	// lanes are replicated so the byte enables pick the right copy
	always_comb begin
		case (memop_i)
			MEM_SB:  sram_wdata_o = {4{rtvalue_i[7:0]}};
			MEM_SH:  sram_wdata_o = {2{rtvalue_i[15:0]}};
			default: sram_wdata_o = rtvalue_i;
		endcase
	end

endmodule

//--- verilog/ex_mem_reg.sv
`timescale 1ns/10ps

module ex_mem_reg
	import mips_pkg::*;
(
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              stall_i,
	input  logic              flush_i,

	input  logic              wren_i,
	input  logic [REG_AW-1:0] waddr_i,
	input  logic [XLEN-1:0]   wdata_i,
	input  mem_op_e           memop_i,
	input  logic [1:0]        addr_low_i,
	input  logic              nofwd_i,
	input  logic [XLEN-1:0]   pc_i,

	output logic              wren_o,
	output logic [REG_AW-1:0] waddr_o,
	output logic [XLEN-1:0]   wdata_o,
	output mem_op_e           memop_o,
	output logic [1:0]        addr_low_o,
	output logic              nofwd_o,
	output logic [XLEN-1:0]   pc_o
);

	logic en;

	assign en = ~stall_i;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wren_o     <= 1'b0;
			waddr_o    <= '0;
			wdata_o    <= '0;
			memop_o    <= MEM_NONE;
			addr_low_o <= 2'b00;
			nofwd_o    <= 1'b0;
			pc_o       <= '0;
		end else if (en) begin
			if (flush_i) begin	// bubble
				wren_o     <= 1'b0;
				waddr_o    <= '0;
				wdata_o    <= '0;
				memop_o    <= MEM_NONE;
				addr_low_o <= 2'b00;
				nofwd_o    <= 1'b0;
				pc_o       <= '0;
			end else begin
				wren_o     <= wren_i;
				waddr_o    <= waddr_i;
				wdata_o    <= wdata_i;
				memop_o    <= memop_i;
				addr_low_o <= addr_low_i;
				nofwd_o    <= nofwd_i;
				pc_o       <= pc_i;
			end
		end
	end

endmodule

//--- verilog/load_align.sv
`timescale 1ns/10ps

module load_align
	import mips_pkg::*;
(
	input  mem_op_e         memop_i,
	input  logic [1:0]      addr_low_i,
	input  logic [XLEN-1:0] rdata_i,
	input  logic [XLEN-1:0] alures_i,
	output logic [XLEN-1:0] wdata_o
);

	logic [7:0]  ld_byte;
	logic [15:0] ld_half;

	// little endian lane select
	always_comb begin
		case (addr_low_i)
			2'b00:   ld_byte = rdata_i[7:0];
			2'b01:   ld_byte = rdata_i[15:8];
			2'b10:   ld_byte = rdata_i[23:16];
			default: ld_byte = rdata_i[31:24];
		endcase
	end

	assign ld_half = addr_low_i[1] ? rdata_i[31:16] : rdata_i[15:0];

	always_comb begin
		if (is_load(memop_i)) begin
			case (memop_i)
				MEM_LB:  wdata_o = {{(XLEN-8){ld_byte[7]}}, ld_byte};
				MEM_LBU: wdata_o = {{(XLEN-8){1'b0}}, ld_byte};
				MEM_LH:  wdata_o = {{(XLEN-16){ld_half[15]}}, ld_half};
				MEM_LHU: wdata_o = {{(XLEN-16){1'b0}}, ld_half};
				default: wdata_o = rdata_i;	// lw
			endcase
		end else begin
			wdata_o = alures_i;	// alu result and stores
		end
	end

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/10ps

module execute_stage
	import mips_pkg::*;
(
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              ex_stall_i,	// from controller
	input  logic              ex_flush_i,

	input  logic [XLEN-1:0]   ex_pc_i,
	input  logic [XLEN-1:0]   ex_opr1_i,
	input  logic [XLEN-1:0]   ex_opr2_i,
	input  logic [XLEN-1:0]   ex_rtvalue_i,
	input  alu_op_e           ex_aluop_i,
	input  mem_op_e           ex_memop_i,
	input  logic              ex_wren_i,
	input  logic [REG_AW-1:0] ex_waddr_i,
	input  logic              ex_nofwd_i,

	input  logic [XLEN-1:0]   data_sram_rdata_i,
	output logic              data_sram_en_o,
	output logic [BE_W-1:0]   data_sram_wen_o,
	output logic [XLEN-1:0]   data_sram_addr_o,
	output logic [XLEN-1:0]   data_sram_wdata_o,

	// bypass
	output logic [XLEN-1:0]   ex_wdata_bp_o,
	output logic              ex_nofwd_bp_o,

	output logic              mem_wren_o,
	output logic [REG_AW-1:0] mem_waddr_o,
	output logic [XLEN-1:0]   mem_wdata_o,
	output logic              mem_nofwd_o,
	output logic [XLEN-1:0]   mem_pc_o
);

	logic [XLEN-1:0] alu_res;
	mem_op_e         mem_memop;
	logic [1:0]      mem_addr_low;
	logic [XLEN-1:0] mem_alures;

	alu alu_i (
		.opr1_i  (ex_opr1_i),
		.opr2_i  (ex_opr2_i),
		.aluop_i (ex_aluop_i),
		.res_o   (alu_res)
	);

	store_format store_format_i (
		.addr_i       (alu_res),	// effective address
		.rtvalue_i    (ex_rtvalue_i),
		.memop_i      (ex_memop_i),
		.sram_en_o    (data_sram_en_o),
		.sram_wen_o   (data_sram_wen_o),
		.sram_addr_o  (data_sram_addr_o),
		.sram_wdata_o (data_sram_wdata_o)
	);

	ex_mem_reg ex_mem_reg_i (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.stall_i    (ex_stall_i),
		.flush_i    (ex_flush_i),
		.wren_i     (ex_wren_i),
		.waddr_i    (ex_waddr_i),
		.wdata_i    (alu_res),
		.memop_i    (ex_memop_i),
		.addr_low_i (alu_res[1:0]),
		.nofwd_i    (ex_nofwd_i),
		.pc_i       (ex_pc_i),
		.wren_o     (mem_wren_o),
		.waddr_o    (mem_waddr_o),
		.wdata_o    (mem_alures),
		.memop_o    (mem_memop),
		.addr_low_o (mem_addr_low),
		.nofwd_o    (mem_nofwd_o),
		.pc_o       (mem_pc_o)
	);

	load_align load_align_i (
		.memop_i    (mem_memop),
		.addr_low_i (mem_addr_low),
		.rdata_i    (data_sram_rdata_i),
		.alures_i   (mem_alures),
		.wdata_o    (mem_wdata_o)
	);

	assign ex_wdata_bp_o = alu_res;
	assign ex_nofwd_bp_o = ex_nofwd_i;

endmodule

//--- test/execute_stage_sva.sv
`timescale 1ns/10ps

module execute_stage_sva
	import mips_pkg::*;
(
	input logic              clk_i,
	input logic              rst_n_i,
	input logic              stall_i,
	input logic              flush_i,
	input mem_op_e           req_memop_i,
	input logic [BE_W-1:0]   req_wen_i,
	input logic [XLEN-1:0]   req_addr_i,
	input logic              wren_i,
	input logic [REG_AW-1:0] waddr_i,
	input logic [XLEN-1:0]   pc_i,
	input logic              nofwd_i,
	input mem_op_e           memop_q_i,
	input logic [XLEN-1:0]   wdata_i
);

	addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		req_addr_i[1:0] == 2'b00)
		else $error("sram address is not word aligned");

	// loads and bubbles write nothing
	wen_only_on_store: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(req_memop_i inside {MEM_SB, MEM_SH, MEM_SW}) |-> req_wen_i == '0)
		else $error("byte enables set without a store");

	hold_on_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		stall_i |=> $stable(wren_i) && $stable(waddr_i) && $stable(pc_i)
			&& $stable(nofwd_i) && $stable(memop_q_i) && $stable(wdata_i))
		else $error("EX/MEM outputs changed during a stall");

	flush_clears: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(flush_i && !stall_i) |=> !wren_i)
		else $error("write enable still set after a flush");

endmodule

bind execute_stage execute_stage_sva sva_i (
	.clk_i       (clk_i),
	.rst_n_i     (rst_n_i),
	.stall_i     (ex_stall_i),
	.flush_i     (ex_flush_i),
	.req_memop_i (ex_memop_i),
	.req_wen_i   (data_sram_wen_o),
	.req_addr_i  (data_sram_addr_o),
	.wren_i      (mem_wren_o),
	.waddr_i     (mem_waddr_o),
	.pc_i        (mem_pc_o),
	.nofwd_i     (mem_nofwd_o),
	.memop_q_i   (mem_memop),
	.wdata_i     (mem_wdata_o)
);

//--- test/execute_stage_tb.sv
`timescale 1ns/10ps

module execute_stage_tb
	import mips_pkg::*;
();

	typedef struct {
		alu_op_e           aluop;
		mem_op_e           memop;
		logic [XLEN-1:0]   opr1;
		logic [XLEN-1:0]   opr2;
		logic [XLEN-1:0]   rtvalue;
		logic [REG_AW-1:0] waddr;
		logic              wren;
		logic              stall;
		logic              flush;
		logic              rnd;	// operands from lcg
	} row_t;

	logic              clk = 1'b0;
	logic              rst_n;
	logic              stall;
	logic              flush;
	logic [XLEN-1:0]   pc;
	logic [XLEN-1:0]   opr1;
	logic [XLEN-1:0]   opr2;
	logic [XLEN-1:0]   rtvalue;
	alu_op_e           aluop;
	mem_op_e           memop;
	logic              wren;
	logic [REG_AW-1:0] waddr;
	logic              nofwd;
	logic [XLEN-1:0]   sram_rdata = '0;
	logic              sram_en;
	logic [BE_W-1:0]   sram_wen;
	logic [XLEN-1:0]   sram_addr;
	logic [XLEN-1:0]   sram_wdata;
	logic [XLEN-1:0]   bp_wdata;
	logic              bp_nofwd;
	logic              mem_wren;
	logic [REG_AW-1:0] mem_waddr;
	logic [XLEN-1:0]   mem_wdata;
	logic              mem_nofwd;
	logic [XLEN-1:0]   mem_pc;

	row_t            rows[$];
	logic [31:0]     lcg_state = 32'h10fded66;
	logic [XLEN-1:0] sram [0:15];
	logic [XLEN-1:0] ref_mem [0:15];	// expected sram contents

	// expected EX/MEM register
	logic              exp_wren;
	logic [REG_AW-1:0] exp_waddr;
	logic [XLEN-1:0]   exp_pc;
	logic              exp_nofwd;
	mem_op_e           exp_memop;
	logic [1:0]        exp_low;
	logic [XLEN-1:0]   exp_alures;
	logic [XLEN-1:0]   exp_rdata;

	int checks = 0;
	int word_errs = 0;
	int be_errs = 0;
	int reg_errs = 0;
	int bit_errs = 0;
	int cycles = 0;
	int cycle_limit = 1000000;

	always #2 clk = ~clk;

	execute_stage dut_i (
		.clk_i (clk), .rst_n_i (rst_n), .ex_stall_i (stall), .ex_flush_i (flush),
		.ex_pc_i (pc), .ex_opr1_i (opr1), .ex_opr2_i (opr2), .ex_rtvalue_i (rtvalue),
		.ex_aluop_i (aluop), .ex_memop_i (memop), .ex_wren_i (wren), .ex_waddr_i (waddr),
		.ex_nofwd_i (nofwd), .data_sram_rdata_i (sram_rdata), .data_sram_en_o (sram_en),
		.data_sram_wen_o (sram_wen), .data_sram_addr_o (sram_addr),
		.data_sram_wdata_o (sram_wdata), .ex_wdata_bp_o (bp_wdata), .ex_nofwd_bp_o (bp_nofwd),
		.mem_wren_o (mem_wren), .mem_waddr_o (mem_waddr), .mem_wdata_o (mem_wdata),
		.mem_nofwd_o (mem_nofwd), .mem_pc_o (mem_pc)
	);

	// 16 word sram, read first, frozen while stalled
	always @(posedge clk) begin
		if (sram_en && !stall) begin
			sram_rdata <= sram[sram_addr[5:2]];
			for (int b = 0; b < BE_W; b++) begin
				if (sram_wen[b])
					sram[sram_addr[5:2]][8*b +: 8] <= sram_wdata[8*b +: 8];
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [XLEN-1:0] fill_word(input int idx);
		logic [XLEN-1:0] w;
		logic [7:0]      a;
		for (int b = 0; b < BE_W; b++) begin
			a = 8'(idx * 4 + b);	// byte address
			w[8*b +: 8] = a * 8'd37 + 8'h91;
		end
		return w;
	endfunction

	function automatic logic [XLEN-1:0] alu_ref(input alu_op_e op, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b);
		logic [63:0] ext;
		ext = {{32{b[31]}}, b} >> a[4:0];
		case (op)
			ALU_ADD:  return a + b;
			ALU_SUB:  return a + ~b + 32'd1;
			ALU_AND:  return a & b;
			ALU_OR:   return a | b;
			ALU_XOR:  return a ^ b;
			ALU_NOR:  return ~a & ~b;
			ALU_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
			ALU_SLTU: return {31'b0, a < b};
			ALU_SLL:  return b << a[4:0];
			ALU_SRL:  return b >> a[4:0];
			ALU_SRA:  return ext[31:0];
			ALU_LUI:  return {b[15:0], 16'h0000};
			default:  return '0;
		endcase
	endfunction

	function automatic logic [BE_W-1:0] be_ref(input mem_op_e op, input logic [1:0] low);
		logic [BE_W-1:0] be;
		be = '0;
		case (op)
			MEM_SB:  be[low] = 1'b1;
			MEM_SH:  be = low[1] ? 4'b1100 : 4'b0011;
			MEM_SW:  be = 4'b1111;
			default: be = '0;
		endcase
		return be;
	endfunction

	function automatic logic [XLEN-1:0] wdata_ref(input mem_op_e op, input logic [XLEN-1:0] rt);
		case (op)
			MEM_SB:  return {rt[7:0], rt[7:0], rt[7:0], rt[7:0]};
			MEM_SH:  return {rt[15:0], rt[15:0]};
			default: return rt;
		endcase
	endfunction

	function automatic logic [XLEN-1:0] load_ref(input mem_op_e op, input logic [1:0] low,
			input logic [XLEN-1:0] rdata, input logic [XLEN-1:0] alures);
		logic [7:0]  by;
		logic [15:0] hw;
		by = rdata[8*low +: 8];
		hw = rdata[16*low[1] +: 16];
		case (op)
			MEM_LB:  return {{24{by[7]}}, by};
			MEM_LBU: return {24'b0, by};
			MEM_LH:  return {{16{hw[15]}}, hw};
			MEM_LHU: return {16'b0, hw};
			MEM_LW:  return rdata;
			default: return alures;
		endcase
	endfunction

	task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
			input string what);
		checks++;
		if (got !== exp) begin
			word_errs++;
			$display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_be(input logic [BE_W-1:0] got, input logic [BE_W-1:0] exp,
			input string what);
		checks++;
		if (got !== exp) begin
			be_errs++;
			$display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_reg(input logic [REG_AW-1:0] got, input logic [REG_AW-1:0] exp,
			input string what);
		checks++;
		if (got !== exp) begin
			reg_errs++;
			$display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			bit_errs++;
			$display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// flags are {wren, stall, flush, rnd}
	task automatic add_row(input alu_op_e op, input mem_op_e mop, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b, input logic [XLEN-1:0] rt, input logic [REG_AW-1:0] wa,
			input logic [3:0] flags);
		row_t r;
		r = '{op, mop, a, b, rt, wa, flags[3], flags[2], flags[1], flags[0]};
		rows.push_back(r);
	endtask

	task automatic build_table();
		for (int k = 0; k < 12; k++) begin
			add_row(alu_op_e'(k), MEM_NONE, 32'hffff_fff4, 32'h8001_2345, '0, 5'(k), 4'b1000);
			add_row(alu_op_e'(k), MEM_NONE, 32'h3, 32'h7ffe_00c8, '0, 5'(k + 12), 4'b1000);
			add_row(alu_op_e'(k), MEM_NONE, '0, '0, '0, 5'(k + 1), 4'b1001);
		end
		// byte stores into word 4, then read back
		for (int k = 0; k < 4; k++)
			add_row(ALU_ADD, MEM_SB, 32'h10, 32'(k), 32'hdead_be00 | 32'(k * 49 + 23), '0, 4'b0000);
		add_row(ALU_ADD, MEM_LW, 32'h10, '0, '0, 5'd3, 4'b1000);
		for (int k = 0; k < 2; k++)
			add_row(ALU_ADD, MEM_SH, 32'h14, 32'(2 * k), 32'h7777_8a01 + 32'(k * 7905), '0, 4'b0000);
		add_row(ALU_ADD, MEM_LW, 32'h14, '0, '0, 5'd4, 4'b1000);
		add_row(ALU_OR, MEM_SW, 32'h18, '0, 32'h8c7f_e213, '0, 4'b0000);
		add_row(ALU_ADD, MEM_LW, 32'h18, '0, '0, 5'd5, 4'b1000);
		// extending loads from word 6
		for (int k = 0; k < 4; k++) begin
			add_row(ALU_ADD, MEM_LB, 32'h18, 32'(k), '0, 5'(k + 8), 4'b1000);
			add_row(ALU_ADD, MEM_LBU, 32'h18, 32'(k), '0, 5'(k + 16), 4'b1000);
		end
		for (int k = 0; k < 2; k++) begin
			add_row(ALU_ADD, MEM_LH, 32'h18, 32'(2 * k), '0, 5'(k + 20), 4'b1000);
			add_row(ALU_ADD, MEM_LHU, 32'h18, 32'(2 * k), '0, 5'(k + 24), 4'b1000);
		end
		add_row(ALU_ADD, MEM_LW, 32'h20, 32'h4, '0, 5'd6, 4'b1000);	// untouched word
		// stall hold, also across a load
		add_row(ALU_ADD, MEM_NONE, 32'h100, 32'h23, '0, 5'd7, 4'b1000);
		for (int k = 0; k < 3; k++)
			add_row(ALU_SUB, MEM_NONE, 32'(k), 32'h55, '0, 5'd9, 4'b1100);
		add_row(ALU_ADD, MEM_LH, 32'h10, 32'h2, '0, 5'd10, 4'b1000);
		for (int k = 0; k < 2; k++)
			add_row(ALU_ADD, MEM_LB, 32'h10, 32'(k), '0, 5'd11, 4'b1100);
		add_row(ALU_XOR, MEM_NONE, 32'hf0f0, 32'h0ff0, '0, 5'd12, 4'b1000);
		// flush, then a flush held off by stall
		add_row(ALU_ADD, MEM_NONE, 32'h7, 32'h8, '0, 5'd13, 4'b1000);
		add_row(ALU_ADD, MEM_NONE, 32'h9, 32'ha, '0, 5'd14, 4'b1010);
		add_row(ALU_AND, MEM_NONE, 32'hff, 32'h3c, '0, 5'd15, 4'b1000);
		add_row(ALU_OR, MEM_NONE, 32'h1, 32'h2, '0, 5'd16, 4'b1110);
		add_row(ALU_SUB, MEM_NONE, 32'h1, 32'h2, '0, 5'd17, 4'b1000);
	endtask

	task automatic drive_row(input row_t r, input int idx);
		aluop   = r.aluop;
		memop   = r.memop;
		opr1    = r.rnd ? next_rand() : r.opr1;
		opr2    = r.rnd ? next_rand() : r.opr2;
		rtvalue = r.rtvalue;
		waddr   = r.waddr;
		wren    = r.wren;
		stall   = r.stall;
		flush   = r.flush;
		nofwd   = r.memop inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};	// load use
		pc      = 32'h0040_0000 + 32'(idx * 4);
	endtask

	task automatic check_request();
		logic [XLEN-1:0] res;
		res = alu_ref(aluop, opr1, opr2);
		check_word(bp_wdata, res, "bypass data");
		check_bit(bp_nofwd, nofwd, "bypass nofwd");
		check_bit(sram_en, memop != MEM_NONE, "sram enable");
		check_word(sram_addr, {res[31:2], 2'b00}, "sram address");
		check_be(sram_wen, be_ref(memop, res[1:0]), "sram byte enables");
		check_word(sram_wdata, wdata_ref(memop, rtvalue), "sram write data");
	endtask

	task automatic update_model();
		logic [XLEN-1:0] res;
		logic [BE_W-1:0] be;
		logic [XLEN-1:0] wd;
		int              idx;
		res = alu_ref(aluop, opr1, opr2);
		if (!stall) begin
			exp_wren   = flush ? 1'b0 : wren;
			exp_waddr  = flush ? '0 : waddr;
			exp_pc     = flush ? '0 : pc;
			exp_nofwd  = flush ? 1'b0 : nofwd;
			exp_memop  = flush ? MEM_NONE : memop;
			exp_low    = flush ? 2'b00 : res[1:0];
			exp_alures = flush ? '0 : res;
			if (memop != MEM_NONE) begin
				idx = int'(res[5:2]);
				be = be_ref(memop, res[1:0]);
				wd = wdata_ref(memop, rtvalue);
				exp_rdata = ref_mem[idx];
				for (int b = 0; b < BE_W; b++) begin
					if (be[b])
						ref_mem[idx][8*b +: 8] = wd[8*b +: 8];
				end
			end
		end
	endtask

	task automatic check_mem();
		check_bit(mem_wren, exp_wren, "mem wren");
		check_reg(mem_waddr, exp_waddr, "mem waddr");
		check_word(mem_wdata, load_ref(exp_memop, exp_low, exp_rdata, exp_alures), "mem wdata");
		check_bit(mem_nofwd, exp_nofwd, "mem nofwd");
		check_word(mem_pc, exp_pc, "mem pc");
	endtask

	initial begin
		int errs;
		rst_n = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		pc = '0;
		opr1 = '0;
		opr2 = '0;
		rtvalue = '0;
		aluop = ALU_ADD;
		memop = MEM_NONE;
		wren = 1'b0;
		waddr = '0;
		nofwd = 1'b0;
		exp_wren = 1'b0;
		exp_waddr = '0;
		exp_pc = '0;
		exp_nofwd = 1'b0;
		exp_memop = MEM_NONE;
		exp_low = 2'b00;
		exp_alures = '0;
		exp_rdata = '0;
		for (int i = 0; i < 16; i++) begin
			sram[i] = fill_word(i);
			ref_mem[i] = fill_word(i);
		end
		build_table();
		cycle_limit = rows.size() * 4 + 20;

		repeat (2) @(negedge clk);
		check_bit(mem_wren, 1'b0, "mem wren after reset");
		check_word(mem_wdata, '0, "mem wdata after reset");
		rst_n = 1'b1;

		for (int i = 0; i < rows.size(); i++) begin
			@(negedge clk);
			check_mem();	// result of the previous row
			drive_row(rows[i], i);
			#1;
			check_request();
			update_model();
		end
		@(negedge clk);
		check_mem();

		errs = word_errs + be_errs + reg_errs + bit_errs;
		$display("%0d checks, errors: data %0d, byte enables %0d, reg addr %0d, flags %0d",
			checks, word_errs, be_errs, reg_errs, bit_errs);
		if (errs == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- execute_stage.f
verilog/mips_pkg.sv
verilog/alu.sv
verilog/store_format.sv
verilog/ex_mem_reg.sv
verilog/load_align.sv
verilog/execute_stage.sv
test/execute_stage_sva.sv
test/execute_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module execute_stage_tb \
	-f execute_stage.f -Mdir obj_dir -o execute_stage_sim \
	|| { echo "verilator build failed"; exit 1; }

out=$(./obj_dir/execute_stage_sim 2>&1)
echo "$out"

echo "$out" | grep -qx "ALL CHECKS PASSED" && exit 0 || { echo "simulation failed"; exit 1; }
